// File: rtl/tl_mem_defs.svh
// bus widths, beat size, bank count and bank depth macros for the banked memory
`ifndef TL_MEM_DEFS_SVH
`define TL_MEM_DEFS_SVH

// byte address width on the A channel
`define TL_ADDR_W 32

// one data beat, in bytes
`define TL_DATA_BYTES 16

// beat width in bits
`define TL_DATA_W (`TL_DATA_BYTES * 8)

// source id carried through to the response
`define TL_SOURCE_W 3

// log2 transfer size field
`define TL_SIZE_W 8

// largest log2 transfer size, 64 bytes = 4 beats
`define TL_MAX_SIZE 6

// banks behind the router
`define MEM_NUM_BANKS 4

// beats held by each bank
`define MEM_BANK_WORDS 256

`endif

// File: rtl/tl_pkg.sv
// TileLink-UL A and D channel payload structs and opcode enumerations
package tl_pkg;

`include "tl_mem_defs.svh"

	// A channel opcodes, UL subset only
	typedef enum logic [2:0] {
		put_full    = 3'd0,
		put_partial = 3'd1,
		get         = 3'd4
	} tl_a_op_e;

	// D channel opcodes
	typedef enum logic [2:0] {
		access_ack      = 3'd0,
		access_ack_data = 3'd1
	} tl_d_op_e;

	// request beat, 194 bits
	typedef struct packed {
		tl_a_op_e                 opcode;
		logic [2:0]               param;
		logic [`TL_SIZE_W-1:0]    size;
		logic [`TL_SOURCE_W-1:0]  source;
		logic [`TL_ADDR_W-1:0]    address;
		logic [`TL_DATA_BYTES-1:0] mask;
		logic [`TL_DATA_W-1:0]    data;
		logic                     corrupt;
	} tl_a_t;

	// response beat, 149 bits
	typedef struct packed {
		tl_d_op_e                 opcode;
		logic [1:0]               param;
		logic [`TL_SIZE_W-1:0]    size;
		logic [`TL_SOURCE_W-1:0]  source;
		logic [2:0]               sink;
		logic                     denied;
		logic [`TL_DATA_W-1:0]    data;
		logic                     corrupt;
	} tl_d_t;

endpackage

// File: rtl/mem_map_pkg.sv
// memory map types for bank select, beat index and beat count, plus size to beats
package mem_map_pkg;

`include "tl_mem_defs.svh"

	// address split: | ignored | bank | word | byte in beat |
	localparam int BEAT_LG  = $clog2(`TL_DATA_BYTES);
	localparam int WORD_W   = $clog2(`MEM_BANK_WORDS);
	localparam int BANK_W   = $clog2(`MEM_NUM_BANKS);
	localparam int BANK_LSB = BEAT_LG + WORD_W;
	// wide enough to hold the largest burst length itself
	localparam int BEAT_CNT_W = `TL_MAX_SIZE - BEAT_LG + 1;

	typedef logic [BANK_W-1:0]     bank_idx_t;
	typedef logic [WORD_W-1:0]     word_addr_t;
	typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

	// beats in a transfer of 2**size bytes
	function automatic beat_cnt_t size_to_beats(input logic [`TL_SIZE_W-1:0] size);
		beat_cnt_t beats;
		// sub-beat sizes still take one beat
		if (size <= BEAT_LG)
			beats = beat_cnt_t'(1);
		// clamp oversize requests to the largest burst
		else if (size >= `TL_MAX_SIZE)
			beats = beat_cnt_t'(1 << (`TL_MAX_SIZE - BEAT_LG));
		else
			beats = beat_cnt_t'(1 << (size - BEAT_LG));
		return beats;
	endfunction

endpackage

// File: rtl/tl_bank_router.sv
// A channel router: bank decode, write burst route lock, ready return
`timescale 1ns/1ps
`include "tl_mem_defs.svh"

module tl_bank_router (
	input  logic                       clk,
	input  logic                       rst,
	input  tl_pkg::tl_a_t              a,
	input  logic                       a_valid,
	output logic                       a_ready,
	output logic [`MEM_NUM_BANKS-1:0]  bank_valid,
	input  logic [`MEM_NUM_BANKS-1:0]  bank_ready
);
	import tl_pkg::*;
	import mem_map_pkg::*;

	// lock state for an open write burst
	logic      lock_q;
	bank_idx_t lock_bank;
	beat_cnt_t remain;

	logic      a_fire;
	logic      a_put;
	beat_cnt_t a_beats;
	bank_idx_t sel;

	// later write beats may carry any address, so follow the lock
	assign sel = lock_q ? lock_bank : a.address[BANK_LSB +: BANK_W];

	// only the selected bank sees valid
	always_comb begin
		bank_valid = '0;
		bank_valid[sel] = a_valid;
	end

	// ready comes back from that same bank
	assign a_ready = bank_ready[sel];
	assign a_fire  = a_valid && a_ready;

	assign a_put   = (a.opcode == put_full) || (a.opcode == put_partial);
	assign a_beats = size_to_beats(a.size);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lock_q    <= 1'b0;
			lock_bank <= '0;
			remain    <= '0;
		end else if (a_fire) begin
			if (lock_q) begin
				// remain counts beats still to come, this one included
				remain <= remain - 1'b1;
				if (remain == beat_cnt_t'(1))
					lock_q <= 1'b0;
			end else if (a_put && a_beats > beat_cnt_t'(1)) begin
				// first beat of a multi-beat put
				lock_q    <= 1'b1;
				lock_bank <= sel;
				remain    <= a_beats - 1'b1;
			end
		end
	end

endmodule

// File: rtl/tl_mem_bank.sv
// one memory bank: burst control, byte-masked writes, held read data, D response
`timescale 1ns/1ps
`include "tl_mem_defs.svh"

module tl_mem_bank (
	input  logic          clk,
	input  logic          rst,
	input  tl_pkg::tl_a_t a,
	input  logic          a_valid,
	output logic          a_ready,
	output tl_pkg::tl_d_t d,
	output logic          d_valid,
	input  logic          d_ready
);
	import tl_pkg::*;
	import mem_map_pkg::*;

	logic [`TL_DATA_W-1:0] mem [`MEM_BANK_WORDS];

	// burst control
	logic       rd_busy;
	logic       wr_busy;
	logic       ack_pend;
	word_addr_t ptr;
	beat_cnt_t  remain;

	// response payload
	logic [`TL_SOURCE_W-1:0] src_q;
	logic [`TL_SIZE_W-1:0]   size_q;
	logic [`TL_DATA_W-1:0]   rd_data;

	logic       a_fire;
	logic       d_fire;
	logic       a_get;
	logic       a_put;
	logic       new_req;
	word_addr_t a_word;
	word_addr_t wr_addr;
	beat_cnt_t  a_beats;

	// no new work while a read streams out or an ack waits
	assign a_ready = !rd_busy && !ack_pend;
	assign d_valid = rd_busy || ack_pend;
	assign a_fire  = a_valid && a_ready;
	assign d_fire  = d_valid && d_ready;

	assign a_get   = a.opcode == get;
	assign a_put   = (a.opcode == put_full) || (a.opcode == put_partial);
	// first beat of a request, later put beats arrive with wr_busy set
	assign new_req = a_fire && !wr_busy;
	assign a_word  = a.address[BEAT_LG +: WORD_W];
	assign a_beats = size_to_beats(a.size);
	assign wr_addr = wr_busy ? ptr : a_word;

	// remain holds beats left after the current one
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_busy  <= 1'b0;
			wr_busy  <= 1'b0;
			ack_pend <= 1'b0;
			ptr      <= '0;
			remain   <= '0;
		end else begin
			if (new_req && a_get) begin
				rd_busy <= 1'b1;
				ptr     <= a_word + 1'b1;
				remain  <= a_beats - 1'b1;
			end else if (new_req && a_put) begin
				ptr    <= a_word + 1'b1;
				remain <= a_beats - 1'b1;
				// single beat put acks straight away
				if (a_beats == beat_cnt_t'(1))
					ack_pend <= 1'b1;
				else
					wr_busy <= 1'b1;
			end else if (a_fire && wr_busy) begin
				ptr    <= ptr + 1'b1;
				remain <= remain - 1'b1;
				// last put beat
				if (remain == beat_cnt_t'(1)) begin
					wr_busy  <= 1'b0;
					ack_pend <= 1'b1;
				end
			end
			// never together with a_fire, ready and valid exclude each other
			if (d_fire) begin
				if (ack_pend)
					ack_pend <= 1'b0;
				else if (remain == '0)
					rd_busy <= 1'b0;
				else begin
					ptr    <= ptr + 1'b1;
					remain <= remain - 1'b1;
				end
			end
		end
	end

	// byte lanes written only where the mask is set
	always_ff @(posedge clk) begin
		if (a_fire && (wr_busy || a_put)) begin
			for (int i = 0; i < `TL_DATA_BYTES; i++) begin
				if (a.mask[i])
					mem[wr_addr][i*8 +: 8] <= a.data[i*8 +: 8];
			end
		end
	end

	// read register only moves on a D transfer, so a stalled beat stays put
	always_ff @(posedge clk) begin
		if (new_req && a_get)
			rd_data <= mem[a_word];
		else if (d_fire && rd_busy && remain != '0)
			rd_data <= mem[ptr];
	end

	// echo source and size of the request
	always_ff @(posedge clk) begin
		if (new_req) begin
			src_q  <= a.source;
			size_q <= a.size;
		end
	end

	// denied, corrupt, param and sink all zero
	always_comb begin
		d = '0;
		d.opcode = rd_busy ? access_ack_data : access_ack;
		d.size   = size_q;
		d.source = src_q;
		d.data   = rd_data;
	end

endmodule

// File: rtl/tl_resp_arbiter.sv
// round-robin D channel arbiter, grant held for a whole response
`timescale 1ns/1ps
`include "tl_mem_defs.svh"

module tl_resp_arbiter (
	input  logic                      clk,
	input  logic                      rst,
	input  tl_pkg::tl_d_t             bank_d [`MEM_NUM_BANKS],
	input  logic [`MEM_NUM_BANKS-1:0] bank_d_valid,
	output logic [`MEM_NUM_BANKS-1:0] bank_d_ready,
	output tl_pkg::tl_d_t             d,
	output logic                      d_valid,
	input  logic                      d_ready
);
	import tl_pkg::*;
	import mem_map_pkg::*;

	// grant state
	logic      busy_q;
	bank_idx_t grant_q;
	bank_idx_t last_q;
	beat_cnt_t remain;

	logic      found;
	bank_idx_t pick;
	bank_idx_t cand;
	bank_idx_t sel;
	beat_cnt_t beats;
	logic      d_fire;

	// search starts one past the last winner
	always_comb begin
		found = 1'b0;
		pick  = last_q;
		for (int i = 1; i <= `MEM_NUM_BANKS; i++) begin
			cand = bank_idx_t'(last_q + i);
			if (!found && bank_d_valid[cand]) begin
				found = 1'b1;
				pick  = cand;
			end
		end
	end

	// once a response shows on D, keep it until its last beat
	assign sel     = busy_q ? grant_q : pick;
	assign d       = bank_d[sel];
	assign d_valid = bank_d_valid[sel];
	assign d_fire  = d_valid && d_ready;

	always_comb begin
		bank_d_ready = '0;
		bank_d_ready[sel] = d_ready;
	end

	// acks are one beat, data responses follow the size
	assign beats = (bank_d[sel].opcode == access_ack_data) ? size_to_beats(bank_d[sel].size)
		: beat_cnt_t'(1);

	// remain counts beats not yet transferred
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy_q  <= 1'b0;
			grant_q <= '0;
			last_q  <= bank_idx_t'(`MEM_NUM_BANKS - 1);
			remain  <= '0;
		end else if (!busy_q) begin
			if (found) begin
				if (d_fire && beats == beat_cnt_t'(1)) begin
					last_q <= pick;
				end else begin
					busy_q  <= 1'b1;
					grant_q <= pick;
					remain  <= beats - beat_cnt_t'(d_fire);
				end
			end
		end else if (d_fire) begin
			if (remain == beat_cnt_t'(1)) begin
				busy_q <= 1'b0;
				last_q <= grant_q;
			end else begin
				remain <= remain - 1'b1;
			end
		end
	end

endmodule

// File: rtl/tl_mem_subsys.sv
// banked TileLink-UL memory top: router, bank array, response arbiter
`timescale 1ns/1ps
`include "tl_mem_defs.svh"

module tl_mem_subsys (
	input  logic          clk,
	input  logic          rst,
	input  tl_pkg::tl_a_t a,
	input  logic          a_valid,
	output logic          a_ready,
	output tl_pkg::tl_d_t d,
	output logic          d_valid,
	input  logic          d_ready
);
	import tl_pkg::*;

	// per-bank A handshake
	logic [`MEM_NUM_BANKS-1:0] bank_valid;
	logic [`MEM_NUM_BANKS-1:0] bank_ready;

	// per-bank D streams into the arbiter
	tl_d_t                     bank_d [`MEM_NUM_BANKS];
	logic [`MEM_NUM_BANKS-1:0] bank_d_valid;
	logic [`MEM_NUM_BANKS-1:0] bank_d_ready;

	tl_bank_router tl_bank_router_inst (
		.clk        (clk),
		.rst        (rst),
		.a          (a),
		.a_valid    (a_valid),
		.a_ready    (a_ready),
		.bank_valid (bank_valid),
		.bank_ready (bank_ready)
	);

	// A payload goes to every bank, valid to one
	for (genvar i = 0; i < `MEM_NUM_BANKS; i++) begin : g_bank
		tl_mem_bank tl_mem_bank_inst (
			.clk     (clk),
			.rst     (rst),
			.a       (a),
			.a_valid (bank_valid[i]),
			.a_ready (bank_ready[i]),
			.d       (bank_d[i]),
			.d_valid (bank_d_valid[i]),
			.d_ready (bank_d_ready[i])
		);
	end

	tl_resp_arbiter tl_resp_arbiter_inst (
		.clk          (clk),
		.rst          (rst),
		.bank_d       (bank_d),
		.bank_d_valid (bank_d_valid),
		.bank_d_ready (bank_d_ready),
		.d            (d),
		.d_valid      (d_valid),
		.d_ready      (d_ready)
	);

endmodule

// File: bench/tl_mem_assertions.sv
// concurrent checks on D channel stability and response hold under a grant
`timescale 1ns/1ps

module tl_mem_assertions (
	input logic          clk,
	input logic          rst,
	input tl_pkg::tl_d_t d,
	input logic          d_valid,
	input logic          d_ready,
	input logic          busy
);
	import tl_pkg::*;

	// count of assertion failures so far
	int fail_count = 0;

	// stalled beat keeps valid and payload
	property d_held_p;
		@(posedge clk) disable iff (rst)
		(d_valid && !d_ready) |=> (d_valid && $stable(d));
	endproperty

	// while a grant is held, D keeps showing the same response
	property grant_held_p;
		@(posedge clk) disable iff (rst)
		busy |-> ($stable(d.source) && $stable(d.size) && $stable(d.opcode));
	endproperty

	// a response in progress always shows a valid beat
	property busy_valid_p;
		@(posedge clk) disable iff (rst)
		busy |-> d_valid;
	endproperty

	d_held_a: assert property (d_held_p)
		else begin
			fail_count++;
			$error("D payload changed while stalled");
		end
	grant_held_a: assert property (grant_held_p)
		else begin
			fail_count++;
			$error("arbiter switched responses inside a grant");
		end
	busy_valid_a: assert property (busy_valid_p)
		else begin
			fail_count++;
			$error("arbiter busy without a valid beat");
		end

endmodule

// File: bench/tl_mem_subsys_tb.sv
// testbench for the banked TileLink-UL memory: file stimulus, scoreboard, watchdog
`timescale 1ns/1ps
`include "tl_mem_defs.svh"

module tl_mem_subsys_tb;
	import tl_pkg::*;

	localparam int MAX_REQ = 64;
	localparam int NUM_SRC = 1 << `TL_SOURCE_W;

	logic  clk;
	logic  rst;
	tl_a_t a;
	logic  a_valid;
	logic  a_ready;
	tl_d_t d;
	logic  d_valid;
	logic  d_ready;

	// request list from the stim file
	logic [2:0]  req_op   [MAX_REQ];
	logic [7:0]  req_size [MAX_REQ];
	logic [2:0]  req_src  [MAX_REQ];
	logic [31:0] req_addr [MAX_REQ];
	logic [15:0] req_mask [MAX_REQ];
	logic [31:0] req_word [MAX_REQ][4];
	int          n_req;

	// scoreboard, one slot per source
	logic [NUM_SRC-1:0]    pending;
	tl_d_op_e              exp_op    [NUM_SRC];
	logic [7:0]            exp_size  [NUM_SRC];
	int                    exp_beats [NUM_SRC];
	int                    sent      [NUM_SRC];
	logic [`TL_DATA_W-1:0] exp_data  [NUM_SRC][4];

	// monitor state for interleave detection
	logic       in_resp;
	logic [2:0] cur_src;
	int         beat_idx;

	// failures counted by the bound checker
	int assert_fails;

	tl_mem_subsys tl_mem_subsys_inst (
		.clk     (clk),
		.rst     (rst),
		.a       (a),
		.a_valid (a_valid),
		.a_ready (a_ready),
		.d       (d),
		.d_valid (d_valid),
		.d_ready (d_ready)
	);

	bind tl_resp_arbiter tl_mem_assertions tl_mem_assertions_inst (
		.clk     (clk),
		.rst     (rst),
		.d       (d),
		.d_valid (d_valid),
		.d_ready (d_ready),
		.busy    (busy_q)
	);

	assign assert_fails =
		tl_mem_subsys_inst.tl_resp_arbiter_inst.tl_mem_assertions_inst.fail_count;

	always #20 clk = ~clk;

	task automatic stop_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic report_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// idle state right after reset
	task automatic check_idle(input logic got_d_valid, input logic got_a_ready);
		report_value("d_valid", 128'(got_d_valid), 128'(1'b0));
		report_value("a_ready", 128'(got_a_ready), 128'(1'b1));
	endtask

	// data only matters on access_ack_data
	task automatic check_d_beat(input tl_d_t got, input tl_d_t exp);
		report_value("d.opcode", 128'(got.opcode), 128'(exp.opcode));
		report_value("d.size", 128'(got.size), 128'(exp.size));
		report_value("d.source", 128'(got.source), 128'(exp.source));
		report_value("d.param", 128'(got.param), 128'(exp.param));
		report_value("d.sink", 128'(got.sink), 128'(exp.sink));
		report_value("d.denied", 128'(got.denied), 128'(exp.denied));
		report_value("d.corrupt", 128'(got.corrupt), 128'(exp.corrupt));
		if (exp.opcode == access_ack_data)
			report_value("d.data", got.data, exp.data);
	endtask

	// 2**size bytes in 16 byte beats
	function automatic int beats_of(input logic [7:0] size);
		int n;
		if (size <= 8'd4)
			n = 1;
		else
			n = 1 << (int'(size) - 4);
		return n;
	endfunction

	task automatic load_stim();
		int          fd;
		int          n;
		string       line;
		logic [2:0]  op;
		logic [7:0]  sz;
		logic [2:0]  src;
		logic [31:0] addr;
		logic [15:0] mask;
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;
		n_req = 0;
		fd = $fopen("bench/tl_mem_stim.txt", "r");
		if (fd == 0)
			fail_plain("could not open the stimulus file");
		while ($fgets(line, fd) != 0) begin
			// skip comments and blank lines
			if (line.len() > 0 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
					op, sz, src, addr, mask, w0, w1, w2, w3);
				if (n == 9 && n_req < MAX_REQ) begin
					req_op[n_req]      = op;
					req_size[n_req]    = sz;
					req_src[n_req]     = src;
					req_addr[n_req]    = addr;
					req_mask[n_req]    = mask;
					req_word[n_req][0] = w0;
					req_word[n_req][1] = w1;
					req_word[n_req][2] = w2;
					req_word[n_req][3] = w3;
					n_req++;
				end
			end
		end
		$fclose(fd);
		if (n_req == 0)
			fail_plain("stimulus file holds no requests");
	endtask

	// one A beat, held until accepted
	task automatic send_beat(input tl_a_t beat);
		@(negedge clk);
		a       = beat;
		a_valid = 1'b1;
		@(posedge clk);
		while (!a_ready)
			@(posedge clk);
	endtask

	task automatic send_request(input int r);
		logic [2:0] s;
		int         nb;
		tl_a_t      beat;
		s  = req_src[r];
		nb = beats_of(req_size[r]);
		// one outstanding request per source
		while (pending[s])
			@(negedge clk);
		pending[s]  = 1'b1;
		sent[s]     = 0;
		exp_size[s] = req_size[r];
		for (int b = 0; b < 4; b++)
			exp_data[s][b] = {4{req_word[r][b]}};
		if (req_op[r] == 3'd4) begin
			exp_op[s]    = access_ack_data;
			exp_beats[s] = nb;
			beat = '0;
			beat.opcode  = get;
			beat.size    = req_size[r];
			beat.source  = s;
			beat.address = req_addr[r];
			beat.mask    = req_mask[r];
			send_beat(beat);
			sent[s] = 1;
		end else begin
			exp_op[s]    = access_ack;
			exp_beats[s] = 1;
			for (int b = 0; b < nb; b++) begin
				beat = '0;
				beat.opcode  = tl_a_op_e'(req_op[r]);
				beat.size    = req_size[r];
				beat.source  = s;
				beat.address = req_addr[r] + 32'(b * 16);
				beat.mask    = req_mask[r];
				beat.data    = {4{req_word[r][b]}};
				send_beat(beat);
				sent[s] = b + 1;
			end
		end
		@(negedge clk);
		a_valid = 1'b0;
	endtask

	// response monitor
	always @(posedge clk) begin
		logic [2:0] s;
		tl_d_t      exp;
		if (!rst && d_valid && d_ready) begin
			s = d.source;
			if (!pending[s])
				fail_plain("response arrived for a source with no request outstanding");
			if (in_resp && s != cur_src)
				fail_plain("beats of two responses were interleaved");
			if (exp_op[s] == access_ack && sent[s] != beats_of(exp_size[s]))
				fail_plain("write acknowledged before all of its beats were sent");
			exp = '0;
			exp.opcode = exp_op[s];
			exp.size   = exp_size[s];
			exp.source = s;
			exp.data   = exp_data[s][beat_idx];
			check_d_beat(d, exp);
			if (beat_idx + 1 == exp_beats[s]) begin
				pending[s] <= 1'b0;
				in_resp    <= 1'b0;
				beat_idx   <= 0;
			end else begin
				in_resp  <= 1'b1;
				cur_src  <= s;
				beat_idx <= beat_idx + 1;
			end
		end
	end

	// a bound assertion failure ends the run at the next falling edge
	always @(negedge clk) begin
		if (assert_fails != 0)
			fail_plain("a bound assertion on the D channel failed");
	end

	// random back-pressure on D, one seed for the whole run
	initial begin
		void'($urandom(98));
		forever begin
			@(negedge clk);
			if (!rst)
				d_ready = ($urandom % 4) != 0;
		end
	end

	// watchdog sized from the request count
	initial begin
		int timeout_ns;
		wait (n_req > 0);
		timeout_ns = n_req * 4 * 50 * 40;
		#(timeout_ns);
		fail_plain("watchdog expired before all responses arrived");
	end

	initial begin
		clk      = 1'b0;
		rst      = 1'b1;
		a        = '0;
		a_valid  = 1'b0;
		d_ready  = 1'b0;
		pending  = '0;
		in_resp  = 1'b0;
		cur_src  = '0;
		beat_idx = 0;
		load_stim();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_idle(d_valid, a_ready);
		for (int r = 0; r < n_req; r++)
			send_request(r);
		// drain every outstanding response
		while (pending != '0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (assert_fails == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			fail_plain("a bound assertion on the D channel failed");
		end
	end

endmodule

// File: bench/tl_mem_stim.txt
# op(0 put_full,1 put_partial,4 get) size(log2) source address mask w0 w1 w2 w3
# each word fills a 16 byte beat four times over; for get the words are expected beats
# full write burst to bank 0, then read back
0 6 1 00000000 ffff 00000a00 00000a01 00000a02 00000a03
4 6 2 00000000 ffff 00000a00 00000a01 00000a02 00000a03
# two beat write to bank 1, then partial write of byte 0 in each word
0 5 3 00001040 ffff 11223344 55667788 00000000 00000000
1 4 4 00001040 1111 aabbccdd 00000000 00000000 00000000
4 5 5 00001040 ffff 112233dd 55667788 00000000 00000000
# fill bank 2 and bank 3
0 6 6 00002100 ffff 20000000 20000001 20000002 20000003
0 4 7 00003200 ffff 3000000f 00000000 00000000 00000000
# partial burst on bank 3, top byte of each word
1 5 0 00003300 8888 c1000000 c2000000 00000000 00000000
0 5 1 00003400 ffff 31313131 32323232 00000000 00000000
1 5 2 00003400 4444 00ee0000 00ff0000 00000000 00000000
# gets to all four banks back to back
4 6 0 00000000 ffff 00000a00 00000a01 00000a02 00000a03
4 5 1 00001040 ffff 112233dd 55667788 00000000 00000000
4 6 2 00002100 ffff 20000000 20000001 20000002 20000003
4 4 3 00003200 ffff 3000000f 00000000 00000000 00000000
4 5 4 00003300 ffff c1000000 c2000000 00000000 00000000
4 5 5 00003400 ffff 31ee3131 32ff3232 00000000 00000000
# second get to a bank still streaming a burst
4 6 6 00002100 ffff 20000000 20000001 20000002 20000003
4 4 7 00002120 ffff 20000002 00000000 00000000 00000000
# address bits above 13 alias onto the same bank
4 4 0 00010000 ffff 00000a00 00000000 00000000 00000000
4 5 1 00fe1050 ffff 55667788 00000000 00000000 00000000
# overwrite a beat in bank 0 and check both neighbours
0 4 2 00000010 ffff 0b0b0b0b 00000000 00000000 00000000
4 6 3 00000000 ffff 00000a00 0b0b0b0b 00000a02 00000a03
# one more round across all banks
4 4 4 00003200 ffff 3000000f 00000000 00000000 00000000
4 4 5 00002130 ffff 20000003 00000000 00000000 00000000
4 4 6 00001050 ffff 55667788 00000000 00000000 00000000
4 4 7 00000030 ffff 00000a03 00000000 00000000 00000000

// File: sources.f
+incdir+rtl
rtl/tl_pkg.sv
rtl/mem_map_pkg.sv
rtl/tl_bank_router.sv
rtl/tl_mem_bank.sv
rtl/tl_resp_arbiter.sv
rtl/tl_mem_subsys.sv
bench/tl_mem_assertions.sv
bench/tl_mem_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the banked memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f \
	--top-module tl_mem_subsys_tb -o tb_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
